// File: vicPkg.sv
package vicPkg;

  // ----------------------------
  // palette indices
  // ----------------------------
  typedef enum logic [3:0] {
    BLACK,
    WHITE,
    RED,
    CYAN,
    PURPLE,
    GREEN,
    BLUE,
    YELLOW,
    ORANGE,
    BROWN,
    PINK,
    DARK_GREY,
    GREY,
    LIGHT_GREEN,
    LIGHT_BLUE,
    LIGHT_GREY
  } vicColor;

  // register offsets still decoded by the register file
  typedef enum logic [5:0] {
    CTRL1      = 6'h11,
    RASTER     = 6'h12,
    CTRL2      = 6'h16,
    IRQ_STATUS = 6'h19,
    IRQ_ENABLE = 6'h1A,
    BORDER_COL = 6'h20,
    BG_COL0    = 6'h21
  } regAddr;

  // ----------------------------
  // bundles
  // ----------------------------
  // one cpu access, held by the requester until ack
  typedef struct packed {
    regAddr     addr;
    logic       write;
    logic [7:0] wdata;
  } busReq;

  // register fields the pixel pipeline looks at
  typedef struct packed {
    logic    den;
    logic    rsel;
    logic    csel;
    vicColor borderColor;
    vicColor bgColor;
  } vidCtrl;

  typedef struct packed {
    logic [9:0] x;
    logic [8:0] line;
  } rasterPos;

  // final pixel, tagged with where it belongs on the raster
  typedef struct packed {
    rasterPos   pos;
    logic [1:0] red;
    logic [1:0] green;
    logic [1:0] blue;
  } pixelOut;

  // ----------------------------
  // display window edges
  // ----------------------------
  // window arms on this line when den is set, disarms on denEndLine
  localparam logic [8:0] denLine     = 9'd48;
  localparam logic [8:0] denEndLine  = 9'd248;
  // 25 row vs 24 row vertical limits
  localparam logic [8:0] topRow25    = 9'd51;
  localparam logic [8:0] topRow24    = 9'd55;
  localparam logic [8:0] bottomRow25 = 9'd251;
  localparam logic [8:0] bottomRow24 = 9'd247;
  // 40 vs 38 column horizontal limits, in raster x
  localparam logic [9:0] leftCol40   = 10'd24;
  localparam logic [9:0] leftCol38   = 10'd31;
  localparam logic [9:0] rightCol40  = 10'd344;
  localparam logic [9:0] rightCol38  = 10'd335;

  // color index to {red, green, blue}, two bits each
  localparam logic [5:0] vicPalette [16] = '{
    6'b00_00_00, 6'b11_11_11, 6'b10_00_00, 6'b01_11_11,
    6'b10_00_10, 6'b01_10_00, 6'b00_00_10, 6'b11_11_01,
    6'b10_01_00, 6'b01_01_00, 6'b11_01_01, 6'b01_01_01,
    6'b10_10_10, 6'b10_11_01, 6'b01_01_11, 6'b11_11_10
  };

endpackage

// File: rasterTimer.sv
`timescale 1ns/1ps

module rasterTimer #(
  parameter int rasterXMax = 503,
  parameter int rasterYMax = 311
) (
  input  logic             clk_dot4x,
  input  logic             rst,
  output logic             dotEn,
  output vicPkg::rasterPos pos
);

  // one hot ring, dot clock runs at a quarter of clk_dot4x
  logic [3:0] dotRing;
  logic       lastX;
  logic       lastLine;

  // ----------------------------
  // dot enable
  // ----------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dotRing <= 4'b0001;
    end else begin
      dotRing <= {dotRing[2:0], dotRing[3]};
    end
  end

  // high for one clk_dot4x cycle out of every four
  assign dotEn = dotRing[3];

  // ----------------------------
  // raster counters
  // ----------------------------
  assign lastX    = (pos.x == 10'(rasterXMax));
  assign lastLine = (pos.line == 9'(rasterYMax));

  // frame starts at (0,0) after reset
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      pos <= '0;
    end else if (dotEn) begin
      if (lastX) begin
        pos.x <= 10'd0;
        // end of line, step the line or wrap the frame
        if (lastLine) begin
          pos.line <= 9'd0;
        end else begin
          pos.line <= pos.line + 9'd1;
        end
      end else begin
        pos.x <= pos.x + 10'd1;
      end
    end
  end

  // x wraps exactly at the line length, even across the line step
  xInRange: assert property (
    @(posedge clk_dot4x) disable iff (rst)
    pos.x <= 10'(rasterXMax)
  );

endmodule

// File: borderUnit.sv
`timescale 1ns/1ps

module borderUnit (
  input  logic             clk_dot4x,
  input  logic             rst,
  input  logic             dotEn,
  input  vicPkg::rasterPos pos,
  input  vicPkg::vidCtrl   ctrl,
  output vicPkg::rasterPos stagePos,
  output logic             border,
  output logic             stageValid
);

  import vicPkg::*;

  // raster position settles the cycle after dotEn, so act then
  logic       dotEnQ;
  // window armed for this frame
  logic       armed;
  logic       vertBorder;
  logic       horizBorder;
  logic       nextArmed;
  logic       newTopBottom;
  logic       nextVert;
  logic       nextHoriz;
  logic [8:0] topRow;
  logic [8:0] bottomRow;
  logic [9:0] leftCol;
  logic [9:0] rightCol;

  // ----------------------------
  // edge selection
  // ----------------------------
  always_comb begin
    topRow    = ctrl.rsel ? topRow25 : topRow24;
    bottomRow = ctrl.rsel ? bottomRow25 : bottomRow24;
    leftCol   = ctrl.csel ? leftCol40 : leftCol38;
    rightCol  = ctrl.csel ? rightCol40 : rightCol38;
  end

  always_comb begin
    nextArmed = armed;
    if (pos.line == denLine && ctrl.den) begin
      nextArmed = 1'b1;
    end
    if (pos.line == denEndLine) begin
      nextArmed = 1'b0;
    end
    // top/bottom value seen at the left edge
    newTopBottom = vertBorder;
    if (pos.line == topRow && armed) begin
      newTopBottom = 1'b0;
    end
    if (pos.line == bottomRow) begin
      newTopBottom = 1'b1;
    end
    nextVert  = vertBorder;
    nextHoriz = horizBorder;
    if (pos.x == leftCol) begin
      nextVert  = newTopBottom;
      nextHoriz = newTopBottom;
    end
    // right edge always closes the line
    if (pos.x == rightCol) begin
      nextHoriz = 1'b1;
    end
  end

  // ----------------------------
  // flags and stage outputs
  // ----------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dotEnQ      <= 1'b0;
      armed       <= 1'b0;
      vertBorder  <= 1'b1;
      horizBorder <= 1'b1;
      border      <= 1'b1;
      stageValid  <= 1'b0;
    end else begin
      dotEnQ     <= dotEn;
      stageValid <= dotEnQ;
      if (dotEnQ) begin
        armed       <= nextArmed;
        vertBorder  <= nextVert;
        horizBorder <= nextHoriz;
        border      <= nextVert | nextHoriz;
      end
    end
  end

  always_ff @(posedge clk_dot4x) begin
    if (dotEnQ) begin
      stagePos <= pos;
    end
  end

endmodule

// File: colorOut.sv
`timescale 1ns/1ps

module colorOut (
  input  logic             clk_dot4x,
  input  logic             rst,
  input  vicPkg::rasterPos stagePos,
  input  logic             border,
  input  logic             stageValid,
  input  vicPkg::vidCtrl   ctrl,
  output vicPkg::pixelOut  pixel,
  output logic             pixValid
);

  import vicPkg::*;

  vicColor    pixColor;
  logic [5:0] rgb;

  // ----------------------------
  // color pick and lookup
  // ----------------------------
  // no graphics data, the window shows background 0
  always_comb begin
    if (border) begin
      pixColor = ctrl.borderColor;
    end else begin
      pixColor = ctrl.bgColor;
    end
    rgb = vicPalette[pixColor];
  end

  // ----------------------------
  // output register
  // ----------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      pixValid <= 1'b0;
    end else begin
      pixValid <= stageValid;
    end
  end

  always_ff @(posedge clk_dot4x) begin
    if (stageValid) begin
      pixel.pos   <= stagePos;
      pixel.red   <= rgb[5:4];
      pixel.green <= rgb[3:2];
      pixel.blue  <= rgb[1:0];
    end
  end

  // one pixel per dot, the strobe from the timer stays one clock wide
  pixStrobe: assert property (
    @(posedge clk_dot4x) disable iff (rst)
    pixValid |=> !pixValid
  );

endmodule

// File: vicRegs.sv
`timescale 1ns/1ps

module vicRegs #(
  parameter int rasterYMax = 311
) (
  input  logic             clk_dot4x,
  input  logic             rst,
  input  logic             req,
  input  vicPkg::busReq    bus,
  output logic             ack,
  output logic [7:0]       rdata,
  input  logic             dotEn,
  input  vicPkg::rasterPos pos,
  output vicPkg::vidCtrl   ctrl,
  output logic             irq
);

  import vicPkg::*;

  typedef enum logic {
    PORT_IDLE,
    PORT_ACK
  } portState;

  portState   state;
  logic       access;
  logic [7:0] readData;
  // register fields
  logic       den;
  logic       rsel;
  logic       csel;
  vicColor    borderColor;
  vicColor    bgColor;
  logic [8:0] rasterCmp;
  // raster irq status, enable and once per line guard
  logic       irst;
  logic       erst;
  logic       rasterDone;

  // ----------------------------
  // four phase port
  // ----------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      state <= PORT_IDLE;
    end else begin
      case (state)
        PORT_IDLE: if (req) state <= PORT_ACK;
        PORT_ACK:  if (!req) state <= PORT_IDLE;
        default:   state <= PORT_IDLE;
      endcase
    end
  end

  assign ack    = (state == PORT_ACK);
  // the one edge where the access is carried out
  assign access = (state == PORT_IDLE) && req;

  // read mux, unused bits read as 1 unless noted
  always_comb begin
    case (bus.addr)
      CTRL1:      readData = {pos.line[8], 2'b00, den, rsel, 3'b000};
      RASTER:     readData = pos.line[7:0];
      CTRL2:      readData = {4'hF, csel, 3'b111};
      IRQ_STATUS: readData = {irq, 6'b111111, irst};
      IRQ_ENABLE: readData = {7'h7F, erst};
      BORDER_COL: readData = {4'hF, borderColor};
      BG_COL0:    readData = {4'hF, bgColor};
      default:    readData = 8'hFF;
    endcase
  end

  // held stable while ack is up
  always_ff @(posedge clk_dot4x) begin
    if (access && !bus.write) begin
      rdata <= readData;
    end
  end

  // ----------------------------
  // register writes and raster irq
  // ----------------------------
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      den         <= 1'b1;
      rsel        <= 1'b0;
      csel        <= 1'b0;
      borderColor <= BLACK;
      bgColor     <= BLACK;
      rasterCmp   <= 9'd0;
      erst        <= 1'b0;
      irst        <= 1'b0;
      rasterDone  <= 1'b0;
    end else begin
      if (access && bus.write) begin
        case (bus.addr)
          CTRL1: begin
            den          <= bus.wdata[4];
            rsel         <= bus.wdata[3];
            rasterCmp[8] <= bus.wdata[7];
          end
          RASTER:     rasterCmp[7:0] <= bus.wdata;
          CTRL2:      csel <= bus.wdata[3];
          // write one to acknowledge
          IRQ_STATUS: if (bus.wdata[0]) irst <= 1'b0;
          IRQ_ENABLE: erst <= bus.wdata[0];
          BORDER_COL: borderColor <= vicColor'(bus.wdata[3:0]);
          BG_COL0:    bgColor <= vicColor'(bus.wdata[3:0]);
          default:    ;
        endcase
      end
      // compare at the start of the line, a new match wins over a clear
      if (!rasterDone && pos.x == 10'd0 && pos.line == rasterCmp) begin
        irst       <= 1'b1;
        rasterDone <= 1'b1;
      end else if (dotEn && pos.x != 10'd0) begin
        rasterDone <= 1'b0;
      end
    end
  end

  assign ctrl = '{den: den, rsel: rsel, csel: csel,
                  borderColor: borderColor, bgColor: bgColor};
  assign irq  = irst & erst;

  // ack answers a request seen on the edge before
  ackAfterReq: assert property (
    @(posedge clk_dot4x) disable iff (rst)
    $rose(ack) |-> $past(req)
  );

  // compare must name a line that exists, or the irq never fires
  cmpInFrame: assert property (
    @(posedge clk_dot4x) disable iff (rst)
    rasterCmp <= 9'(rasterYMax)
  );

endmodule

// File: vicVideo.sv
`timescale 1ns/1ps

module vicVideo #(
  parameter int rasterXMax = 503,
  parameter int rasterYMax = 311
) (
  input  logic            clk_dot4x,
  input  logic            rst,
  input  logic            req,
  input  vicPkg::busReq   bus,
  output logic            ack,
  output logic [7:0]      rdata,
  output logic            irq,
  output vicPkg::pixelOut pixel,
  output logic            pixValid
);

  import vicPkg::*;

  logic     dotEn;
  rasterPos pos;
  vidCtrl   ctrl;
  // between border stage and color stage
  rasterPos stagePos;
  logic     border;
  logic     stageValid;

  // ----------------------------
  // register file
  // ----------------------------
  vicRegs #(
    .rasterYMax(rasterYMax)
  ) i_vicRegs (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .req(req),
    .bus(bus),
    .ack(ack),
    .rdata(rdata),
    .dotEn(dotEn),
    .pos(pos),
    .ctrl(ctrl),
    .irq(irq)
  );

  // ----------------------------
  // pixel pipeline
  // ----------------------------
  rasterTimer #(
    .rasterXMax(rasterXMax),
    .rasterYMax(rasterYMax)
  ) i_rasterTimer (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .dotEn(dotEn),
    .pos(pos)
  );

  borderUnit i_borderUnit (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .dotEn(dotEn),
    .pos(pos),
    .ctrl(ctrl),
    .stagePos(stagePos),
    .border(border),
    .stageValid(stageValid)
  );

  colorOut i_colorOut (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .stagePos(stagePos),
    .border(border),
    .stageValid(stageValid),
    .ctrl(ctrl),
    .pixel(pixel),
    .pixValid(pixValid)
  );

endmodule

// File: vicChecker.sv
`timescale 1ns/1ps

module vicChecker #(
  parameter int frameClocks = 628992
) (
  input logic            clk_dot4x,
  input logic            ack,
  input logic            irq,
  input logic [7:0]      rdata,
  input vicPkg::pixelOut pixel,
  input logic            pixValid
);

  int runCount;
  int passCount;
  int errorCount;

  initial begin
    runCount   = 0;
    passCount  = 0;
    errorCount = 0;
  end

  // ------------------------------
  // bookkeeping
  // ------------------------------
  task automatic report(input string name, input logic [7:0] expected,
                        input logic [7:0] actual);
    runCount++;
    if (expected === actual) begin
      passCount++;
      $display("PASS  %s: %h", name, actual);
    end else begin
      errorCount++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic noteFailure(input string what);
    errorCount++;
    $display("%s", what);
  endtask

  task automatic printSummary();
    $display("checks run %0d, ok %0d, errors %0d",
             runCount, passCount, errorCount);
  endtask

  // ------------------------------
  // individual checks
  // ------------------------------
  // rdata holds the last read until the next one
  task automatic checkRead(input string name, input logic [7:0] expected);
    report(name, expected, rdata);
  endtask

  // ack in bit 1 and irq in bit 0
  task automatic checkIdle(input string name);
    @(negedge clk_dot4x);
    report(name, 8'h00, {6'b000000, ack, irq});
  endtask

  // sampled on the falling edge where the one clock strobe is stable
  task automatic waitPixel(input logic [8:0] line, input logic [9:0] x, output bit found);
    int waited;
    found  = 1'b0;
    waited = 0;
    while (!found && waited < 2 * frameClocks) begin
      @(negedge clk_dot4x);
      waited++;
      if (pixValid && pixel.pos.line == line && pixel.pos.x == x) found = 1'b1;
    end
  endtask

  task automatic checkPixel(input string name, input logic [8:0] line,
                            input logic [9:0] x, input logic [5:0] expRgb);
    bit found;
    waitPixel(line, x, found);
    if (found) begin
      report(name, {2'b00, expRgb}, {2'b00, pixel.red, pixel.green, pixel.blue});
    end else begin
      noteFailure($sformatf("%s: pixel at line %0d x %0d never showed up", name, line, x));
    end
  endtask

  // irq level seen when the pixel at line/x leaves the pipeline
  task automatic checkIrq(input string name, input logic [8:0] line,
                          input logic [9:0] x, input logic expIrq);
    bit found;
    waitPixel(line, x, found);
    if (found) begin
      report(name, {7'd0, expIrq}, {7'd0, irq});
    end else begin
      noteFailure($sformatf("%s: pixel at line %0d x %0d never showed up", name, line, x));
    end
  endtask

endmodule

// File: tbVicVideo.sv
`timescale 1ns/1ps

module tbVicVideo;

  import vicPkg::*;

  localparam int rasterXMax     = 503;
  localparam int rasterYMax     = 311;
  localparam int clkPeriod      = 20;
  localparam int frameClocks    = (rasterXMax + 1) * (rasterYMax + 1) * 4;
  localparam int maxVectors     = 64;
  // clocks allowed for ack to rise or fall
  localparam int handshakeLimit = 16;

  logic       clk_dot4x;
  logic       rst;
  logic       req;
  busReq      bus;
  logic       ack;
  logic [7:0] rdata;
  logic       irq;
  pixelOut    pixel;
  logic       pixValid;

  // vector table filled from the data file before reset ends
  string       vecName [maxVectors];
  string       vecOp   [maxVectors];
  logic [11:0] vecAddr [maxVectors];
  logic [11:0] vecX    [maxVectors];
  logic [7:0]  vecData [maxVectors];
  int          vecCount;
  bit          loaded;

  // ------------------------------
  // clock, DUT and checker
  // ------------------------------
  initial clk_dot4x = 1'b0;
  always #(clkPeriod / 2) clk_dot4x = ~clk_dot4x;

  vicVideo #(
    .rasterXMax(rasterXMax),
    .rasterYMax(rasterYMax)
  ) i_vicVideo (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .req(req),
    .bus(bus),
    .ack(ack),
    .rdata(rdata),
    .irq(irq),
    .pixel(pixel),
    .pixValid(pixValid)
  );

  vicChecker #(
    .frameClocks(frameClocks)
  ) i_checker (
    .clk_dot4x(clk_dot4x),
    .ack(ack),
    .irq(irq),
    .rdata(rdata),
    .pixel(pixel),
    .pixValid(pixValid)
  );

  // ------------------------------
  // vector reader
  // ------------------------------
  task automatic loadVectors();
    int          fd;
    int          rc;
    int          ch;
    string       tok;
    string       op;
    logic [31:0] a;
    logic [31:0] x;
    logic [31:0] d;
    vecCount = 0;
    fd = $fopen("vicVectors.txt", "r");
    if (fd == 0) begin
      i_checker.noteFailure("could not open vicVectors.txt");
    end else begin
      while (!$feof(fd) && vecCount < maxVectors) begin
        rc = $fscanf(fd, "%s", tok);
        if (rc != 1) break;
        if (tok.getc(0) == "#") begin
          // skip the rest of a comment line
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) ch = $fgetc(fd);
        end else begin
          rc = $fscanf(fd, "%s %h %h %h", op, a, x, d);
          if (rc == 4) begin
            vecName[vecCount] = tok;
            vecOp[vecCount]   = op;
            vecAddr[vecCount] = a[11:0];
            vecX[vecCount]    = x[11:0];
            vecData[vecCount] = d[7:0];
            vecCount++;
          end
        end
      end
      $fclose(fd);
      if (vecCount == 0) i_checker.noteFailure("no vectors found in vicVectors.txt");
    end
  endtask

  // ------------------------------
  // register port driver
  // ------------------------------
  // four phase req/ack driven and sampled on the falling edge
  task automatic busAccess(input logic [5:0] addr, input logic write,
                           input logic [7:0] wdata, input string name);
    int waited;
    @(negedge clk_dot4x);
    bus.addr  = regAddr'(addr);
    bus.write = write;
    bus.wdata = wdata;
    req       = 1'b1;
    waited    = 0;
    do begin
      @(negedge clk_dot4x);
      waited++;
    end while (!ack && waited < handshakeLimit);
    if (!ack) i_checker.noteFailure($sformatf("%s: ack never rose after req", name));
    // only req drops while the bus stays put
    req    = 1'b0;
    waited = 0;
    do begin
      @(negedge clk_dot4x);
      waited++;
    end while (ack && waited < handshakeLimit);
    if (ack) i_checker.noteFailure($sformatf("%s: ack stayed high after req fell", name));
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int i;
    req    = 1'b0;
    bus    = '0;
    rst    = 1'b1;
    loaded = 1'b0;
    loadVectors();
    loaded = 1'b1;
    repeat (4) @(posedge clk_dot4x);
    @(negedge clk_dot4x);
    rst = 1'b0;
    for (i = 0; i < vecCount; i++) begin
      if (vecOp[i] == "wr") begin
        busAccess(vecAddr[i][5:0], 1'b1, vecData[i], vecName[i]);
      end else if (vecOp[i] == "rd") begin
        busAccess(vecAddr[i][5:0], 1'b0, 8'h00, vecName[i]);
        i_checker.checkRead(vecName[i], vecData[i]);
      end else if (vecOp[i] == "pix") begin
        // expected color index becomes RGB through the palette
        i_checker.checkPixel(vecName[i], vecAddr[i][8:0], vecX[i][9:0],
                             vicPalette[vecData[i][3:0]]);
      end else if (vecOp[i] == "irq") begin
        i_checker.checkIrq(vecName[i], vecAddr[i][8:0], vecX[i][9:0], vecData[i][0]);
      end else if (vecOp[i] == "idle") begin
        i_checker.checkIdle(vecName[i]);
      end else begin
        i_checker.noteFailure($sformatf("%s: unknown operation %s", vecName[i], vecOp[i]));
      end
    end
    i_checker.printSummary();
    if (i_checker.errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog allows two frames per vector
  initial begin
    longint limitNs;
    wait (loaded);
    limitNs = longint'((vecCount > 0) ? vecCount : 1) * 2 * frameClocks * clkPeriod;
    #(limitNs);
    $display("watchdog expired after %0d ns, simulation stopped", limitNs);
    $display("test failed");
    $finish;
  end

endmodule

// File: vicVectors.txt
# name op addr_or_line x data_or_expected, numbers in hex
# op: wr/rd register, pix color index at line/x, irq level at line/x, idle ack and irq low
resetIdle idle 0 0 0
resetCtrl1 rd 11 0 10
resetCtrl2 rd 16 0 f7
resetBorder rd 20 0 f0
resetEnable rd 1a 0 fe
borderWrite wr 20 0 0e
borderRead rd 20 0 fe
bgWrite wr 21 0 06
bgRead rd 21 0 f6
enableWrite wr 1a 0 01
enableRead rd 1a 0 ff
enableOff wr 1a 0 00
ctrl2Write wr 16 0 08
ctrl2Read rd 16 0 ff
ctrl1Write wr 11 0 18
ctrl1Read rd 11 0 18
topBorder pix 14 c8 e
col40Window pix 35 1c 6
leftBorder pix 64 0a e
centerWindow pix 64 c8 6
rasterRead rd 12 0 64
bottomBorder pix 104 c8 e
ctrl1Line8 rd 11 0 98
rows24 wr 11 0 10
cols38 wr 16 0 00
row53Border pix 35 c8 e
col28Border pix 64 1c e
narrowWindow pix 64 c8 6
cmpLow wr 12 0 96
statusClear wr 19 0 01
irqEnable wr 1a 0 01
irqBefore irq 95 8 0
irqAtLine irq 96 8 1
statusSet rd 19 0 ff
statusAck wr 19 0 01
irqCleared irq 97 8 0
statusClr rd 19 0 7e
denOff wr 11 0 00
denOffBorder pix 64 c8 e
denOn wr 11 0 10
denOnWindow pix 64 c8 6

// File: vicVideo.f
vicPkg.sv
rasterTimer.sv
borderUnit.sv
colorOut.sv
vicRegs.sv
vicVideo.sv
vicChecker.sv
tbVicVideo.sv
